//--- src/vga_pkg.sv
`default_nettype none

package vga_pkg;

    localparam int coord_w = 10;

    // horizontal timing in pixel clocks
    localparam logic [coord_w-1:0] h_active = 640;
    localparam logic [coord_w-1:0] h_front  = 16;
    localparam logic [coord_w-1:0] h_pulse  = 96;
    localparam logic [coord_w-1:0] h_back   = 48;
    localparam logic [coord_w-1:0] h_total  = h_active + h_front + h_pulse + h_back;

    // vertical timing in lines
    localparam logic [coord_w-1:0] v_active = 480;
    localparam logic [coord_w-1:0] v_front  = 10;
    localparam logic [coord_w-1:0] v_pulse  = 2;
    localparam logic [coord_w-1:0] v_back   = 33;
    localparam logic [coord_w-1:0] v_total  = v_active + v_front + v_pulse + v_back;

    // apb register offsets
    localparam logic [3:0] addr_ctrl   = 4'h0;
    localparam logic [3:0] addr_color  = 4'h4;
    localparam logic [3:0] addr_status = 4'h8;

    typedef enum logic [1:0] {
        mode_solid   = 2'd0,
        mode_bars    = 2'd1,
        mode_checker = 2'd2,
        mode_border  = 2'd3
    } mode_t;

    localparam logic [coord_w-1:0] bar_width = 80;

    // 32 pixel checker cells
    localparam int cell_bit = 5;

endpackage

`default_nettype wire

//--- src/vga_timing.sv
`timescale 1ns/1ns
`default_nettype none

module vga_timing (
    input  wire logic                         clk,
    input  wire logic                         rst,
    output logic      [vga_pkg::coord_w-1:0]  pix_x,
    output logic      [vga_pkg::coord_w-1:0]  pix_y,
    output logic                              active,
    output logic                              hsync,
    output logic                              vsync,
    output logic                              frame_end
);

    // same region order on both axes
    typedef enum logic [1:0] {
        st_active = 2'd0,
        st_front  = 2'd1,
        st_pulse  = 2'd2,
        st_back   = 2'd3
    } region_t;

    region_t h_state;
    region_t v_state;

    logic [vga_pkg::coord_w-1:0] h_cnt;
    logic [vga_pkg::coord_w-1:0] v_cnt;
    logic [vga_pkg::coord_w-1:0] h_len;
    logic [vga_pkg::coord_w-1:0] v_len;

    logic h_wrap;
    logic v_wrap;
    logic line_end;

    function automatic region_t next_region(input region_t cur);
        region_t nxt;
        case (cur)
            st_active: nxt = st_front;
            st_front:  nxt = st_pulse;
            st_pulse:  nxt = st_back;
            default:   nxt = st_active;
        endcase
        return nxt;
    endfunction

    // length of the current horizontal region
    always_comb begin
        case (h_state)
            st_active: h_len = vga_pkg::h_active;
            st_front:  h_len = vga_pkg::h_front;
            st_pulse:  h_len = vga_pkg::h_pulse;
            default:   h_len = vga_pkg::h_back;
        endcase
    end

    always_comb begin
        case (v_state)
            st_active: v_len = vga_pkg::v_active;
            st_front:  v_len = vga_pkg::v_front;
            st_pulse:  v_len = vga_pkg::v_pulse;
            default:   v_len = vga_pkg::v_back;
        endcase
    end

    assign h_wrap   = (h_cnt == h_len - 1'b1);
    assign v_wrap   = (v_cnt == v_len - 1'b1);
    assign line_end = (h_state == st_back) && h_wrap; // last pixel clock of the line

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_state <= st_active;
            h_cnt   <= '0;
        end else if (h_wrap) begin
            h_state <= next_region(h_state);
            h_cnt   <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // vertical machine steps once per line, on its final cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v_state <= st_active;
            v_cnt   <= '0;
        end else if (line_end) begin
            if (v_wrap) begin
                v_state <= next_region(v_state);
                v_cnt   <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end
    end

    assign hsync  = (h_state != st_pulse); // negative polarity
    assign vsync  = (v_state != st_pulse);
    assign active = (h_state == st_active) && (v_state == st_active);

    // last cycle of line 524
    assign frame_end = line_end && (v_state == st_back) && v_wrap;

    always_comb begin
        if (h_state == st_active) begin
            pix_x = h_cnt;
        end else begin
            pix_x = '0;
        end

        if (v_state == st_active) begin
            pix_y = v_cnt;
        end else begin
            pix_y = '0;
        end
    end

endmodule

`default_nettype wire

//--- src/vga_regs.sv
`timescale 1ns/1ns
`default_nettype none

module vga_regs (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 psel,
    input  wire logic                 penable,
    input  wire logic                 pwrite,
    input  wire logic          [3:0]  paddr,
    input  wire logic          [31:0] pwdata,
    output logic               [31:0] prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  wire logic                 frame_end,
    output logic                      enable,
    output vga_pkg::mode_t            mode,
    output logic               [2:0]  fg,
    output logic               [2:0]  bg
);

    logic           access;
    logic           wr_ctrl;
    logic           wr_color;
    logic           addr_ok;

    // staged copies, visible to software
    logic           stg_enable;
    vga_pkg::mode_t stg_mode;
    logic [2:0]     stg_fg;
    logic [2:0]     stg_bg;

    logic [15:0]    frame_cnt;

    assign access   = psel && penable;
    assign wr_ctrl  = access && pwrite && (paddr == vga_pkg::addr_ctrl);
    assign wr_color = access && pwrite && (paddr == vga_pkg::addr_color);

    assign addr_ok = (paddr == vga_pkg::addr_ctrl) ||
                     (paddr == vga_pkg::addr_color) ||
                     (paddr == vga_pkg::addr_status);

    assign pready  = 1'b1; // never waits
    assign pslverr = access && (!addr_ok || (pwrite && paddr == vga_pkg::addr_status));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stg_enable <= 1'b0;
            stg_mode   <= vga_pkg::mode_solid;
            stg_fg     <= '0;
            stg_bg     <= '0;
        end else begin
            if (wr_ctrl) begin
                stg_enable <= pwdata[0];
                stg_mode   <= vga_pkg::mode_t'(pwdata[2:1]);
            end
            if (wr_color) begin
                stg_fg <= pwdata[2:0];
                stg_bg <= pwdata[5:3];
            end
        end
    end

    // live settings switch only between frames
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable    <= 1'b0;
            mode      <= vga_pkg::mode_solid;
            fg        <= '0;
            bg        <= '0;
            frame_cnt <= '0;
        end else if (frame_end) begin
            enable    <= stg_enable;
            mode      <= stg_mode;
            fg        <= stg_fg;
            bg        <= stg_bg;
            frame_cnt <= frame_cnt + 1'b1; // wraps
        end
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                vga_pkg::addr_ctrl:   prdata = {29'd0, stg_mode, stg_enable};
                vga_pkg::addr_color:  prdata = {26'd0, stg_bg, stg_fg};
                vga_pkg::addr_status: prdata = {16'd0, frame_cnt};
                default:              prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/pixel_pattern.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_pattern (
    input  wire logic      [vga_pkg::coord_w-1:0]  pix_x,
    input  wire logic      [vga_pkg::coord_w-1:0]  pix_y,
    input  wire logic                              enable,
    input  wire vga_pkg::mode_t                    mode,
    input  wire logic      [2:0]                   fg,
    input  wire logic      [2:0]                   bg,
    output logic           [2:0]                   rgb_raw
);

    logic [2:0]                  bar_idx;
    logic [vga_pkg::coord_w-1:0] bar_thr;
    logic                        on_edge;
    logic                        cell_odd;

    // bar index by comparing against 80, 160 .. 560
    always_comb begin
        bar_idx = '0;
        bar_thr = vga_pkg::bar_width;
        for (int i = 1; i < 8; i++) begin
            if (pix_x >= bar_thr) begin
                bar_idx = bar_idx + 1'b1;
            end
            bar_thr = bar_thr + vga_pkg::bar_width;
        end
    end

    assign cell_odd = pix_x[vga_pkg::cell_bit] ^ pix_y[vga_pkg::cell_bit];

    // outermost row and column of the visible area
    assign on_edge = (pix_x == '0) ||
                     (pix_x == vga_pkg::h_active - 1'b1) ||
                     (pix_y == '0) ||
                     (pix_y == vga_pkg::v_active - 1'b1);

    always_comb begin
        if (!enable) begin
            rgb_raw = 3'd0;
        end else begin
            case (mode)
                vga_pkg::mode_solid: begin
                    rgb_raw = fg;
                end
                vga_pkg::mode_bars: begin
                    rgb_raw = 3'd7 - bar_idx; // white at the left
                end
                vga_pkg::mode_checker: begin
                    rgb_raw = cell_odd ? fg : bg;
                end
                default: begin
                    rgb_raw = on_edge ? fg : bg;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/vga_top.sv
`timescale 1ns/1ns
`default_nettype none

module vga_top (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         psel,
    input  wire logic                         penable,
    input  wire logic                         pwrite,
    input  wire logic [3:0]                   paddr,
    input  wire logic [31:0]                  pwdata,
    output logic      [31:0]                  prdata,
    output logic                              pready,
    output logic                              pslverr,
    output logic                              hsync,
    output logic                              vsync,
    output logic                              red,
    output logic                              green,
    output logic                              blue,
    output logic      [vga_pkg::coord_w-1:0]  pix_x,
    output logic      [vga_pkg::coord_w-1:0]  pix_y
);

    logic           active;
    logic           frame_end;
    logic           enable;
    vga_pkg::mode_t mode;
    logic [2:0]     fg;
    logic [2:0]     bg;
    logic [2:0]     rgb_raw;

    vga_timing u_timing (
        .clk       (clk),
        .rst       (rst),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .active    (active),
        .hsync     (hsync),
        .vsync     (vsync),
        .frame_end (frame_end)
    );

    vga_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .frame_end (frame_end),
        .enable    (enable),
        .mode      (mode),
        .fg        (fg),
        .bg        (bg)
    );

    pixel_pattern u_pattern (
        .pix_x   (pix_x),
        .pix_y   (pix_y),
        .enable  (enable),
        .mode    (mode),
        .fg      (fg),
        .bg      (bg),
        .rgb_raw (rgb_raw)
    );

    // black outside the visible area
    assign red   = active & rgb_raw[2];
    assign green = active & rgb_raw[1];
    assign blue  = active & rgb_raw[0];

endmodule

`default_nettype wire

//--- verif/vga_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module vga_asserts (
    input wire logic clk,
    input wire logic rst,
    input wire logic hsync,
    input wire logic pready,
    input wire logic frame_end,
    input wire logic red,
    input wire logic green,
    input wire logic blue
);

    int   low_cnt;  // consecutive hsync low cycles
    int   h_pos;
    int   v_pos;
    int   fail_cnt = 0;
    logic outside;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            low_cnt <= 0;
        end else if (!hsync) begin
            low_cnt <= low_cnt + 1;
        end else begin
            low_cnt <= 0;
        end
    end

    // own scan position, region changes follow from it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_pos <= 0;
            v_pos <= 0;
        end else if (h_pos == int'(vga_pkg::h_total) - 1) begin
            h_pos <= 0;
            if (v_pos == int'(vga_pkg::v_total) - 1) begin
                v_pos <= 0;
            end else begin
                v_pos <= v_pos + 1;
            end
        end else begin
            h_pos <= h_pos + 1;
        end
    end

    assign outside = (h_pos >= int'(vga_pkg::h_active)) || (v_pos >= int'(vga_pkg::v_active));

    hsync_width: assert property (@(negedge clk) disable iff (rst)
        $rose(hsync) |-> low_cnt == int'(vga_pkg::h_pulse))
        else begin
            $error("hsync was low for %0d cycles", low_cnt);
            fail_cnt++;
        end

    blank_color: assert property (@(negedge clk) disable iff (rst)
        outside |-> {red, green, blue} == 3'b000)
        else begin
            $error("color not black outside the visible area");
            fail_cnt++;
        end

    ready_high: assert property (@(negedge clk) disable iff (rst) pready)
        else begin
            $error("pready went low");
            fail_cnt++;
        end

    frame_end_pulse: assert property (@(negedge clk) disable iff (rst)
        frame_end |=> !frame_end)
        else begin
            $error("frame_end high for more than one cycle");
            fail_cnt++;
        end

endmodule

`default_nettype wire

//--- verif/tb_vga.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vga;

    localparam int clk_period   = 10;
    localparam int frame_cycles = 420000;
    // six frames of tests plus some margin, about 26 ms
    localparam int watchdog_ns  = 6 * frame_cycles * clk_period + 800000;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        hsync;
    logic        vsync;
    logic        red;
    logic        green;
    logic        blue;
    logic [vga_pkg::coord_w-1:0] pix_x;
    logic [vga_pkg::coord_w-1:0] pix_y;

    int   errors;
    int   checks;
    int   tests_run;
    int   tests_failed;
    int   fe_count;
    int   scan_x;
    int   scan_y;
    logic in_area;
    logic frame_last;
    int   px_q[$];
    int   py_q[$];
    logic [2:0] fg_a;
    logic [2:0] bg_a;
    logic [2:0] fg_b;
    logic [2:0] bg_b;

    vga_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .hsync   (hsync),
        .vsync   (vsync),
        .red     (red),
        .green   (green),
        .blue    (blue),
        .pix_x   (pix_x),
        .pix_y   (pix_y)
    );

    bind vga_top vga_asserts u_asserts (
        .clk       (clk),
        .rst       (rst),
        .hsync     (hsync),
        .pready    (pready),
        .frame_end (frame_end),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // expected scan position, free running from reset
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_x <= 0;
            scan_y <= 0;
        end else if (scan_x == int'(vga_pkg::h_total) - 1) begin
            scan_x <= 0;
            scan_y <= (scan_y == int'(vga_pkg::v_total) - 1) ? 0 : scan_y + 1;
        end else begin
            scan_x <= scan_x + 1;
        end
    end

    assign in_area = (scan_x < int'(vga_pkg::h_active)) && (scan_y < int'(vga_pkg::v_active));

    // scan model decides where each frame ends
    always @(negedge clk) begin
        if (!rst) begin
            frame_last = (scan_x == int'(vga_pkg::h_total) - 1) &&
                         (scan_y == int'(vga_pkg::v_total) - 1);
            check_value("frame_end", u_dut.u_timing.frame_end, frame_last);
            if (frame_last) begin
                fe_count++;
            end
        end
    end

    function automatic logic [2:0] expected_color(input vga_pkg::mode_t m, input logic [2:0] f,
                                                  input logic [2:0] b, input int x, input int y);
        logic [2:0] c;
        case (m)
            vga_pkg::mode_solid:   c = f;
            vga_pkg::mode_bars:    c = 3'(7 - x / int'(vga_pkg::bar_width));
            vga_pkg::mode_checker: begin
                c = (((x >> vga_pkg::cell_bit) ^ (y >> vga_pkg::cell_bit)) & 1) ? f : b;
            end
            default:               c = (x == 0 || x == 639 || y == 0 || y == 479) ? f : b;
        endcase
        return c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t ns %s: got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, errors - err_before);
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #4;
        err = pslverr; // access phase
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #4;
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // checks every cycle against the settings that should still be live
    task automatic wait_frame_end(input logic en, input vga_pkg::mode_t m,
                                  input logic [2:0] f, input logic [2:0] b);
        int         bad;
        logic [2:0] exp;
        bad = 0;
        do begin
            @(negedge clk);
            if (in_area && en) begin
                exp = expected_color(m, f, b, scan_x, scan_y);
            end else begin
                exp = 3'd0;
            end
            if ({red, green, blue} !== exp) begin
                bad++;
            end
        end while (u_dut.u_timing.frame_end !== 1'b1);
        check_value("rgb mismatch count", bad, 0);
        @(posedge clk);
    endtask

    // one random point per band of 30 lines, in scan order
    task automatic make_spread_points();
        px_q.delete();
        py_q.delete();
        for (int k = 0; k < 16; k++) begin
            px_q.push_back($urandom % 640);
            py_q.push_back(k * 30 + $urandom % 30);
        end
    endtask

    task automatic make_border_points();
        int y;
        px_q.delete();
        py_q.delete();
        px_q.push_back($urandom % 640);
        py_q.push_back(0);
        for (int k = 1; k < 15; k++) begin
            y = k * 32 + $urandom % 31;
            px_q.push_back(0);
            py_q.push_back(y);
            px_q.push_back(1 + $urandom % 638);
            py_q.push_back(y);
            px_q.push_back(639);
            py_q.push_back(y);
        end
        px_q.push_back($urandom % 640);
        py_q.push_back(479);
    endtask

    task automatic check_points(input vga_pkg::mode_t m, input logic [2:0] f, input logic [2:0] b);
        @(negedge clk);
        for (int i = 0; i < px_q.size(); i++) begin
            while (!(in_area && scan_x == px_q[i] && scan_y == py_q[i])) begin
                @(negedge clk);
            end
            check_value("pix_x", pix_x, px_q[i]);
            check_value("pix_y", pix_y, py_q[i]);
            check_value("rgb", {red, green, blue}, expected_color(m, f, b, px_q[i], py_q[i]));
        end
    endtask

    task automatic test_reset_defaults();
        int          e0;
        logic [31:0] rd;
        logic        err;
        e0 = errors;
        check_value("rgb", {red, green, blue}, 0);
        check_value("hsync", hsync, 1);
        check_value("vsync", vsync, 1);
        check_value("pix_x", pix_x, 0);
        check_value("pix_y", pix_y, 0);
        apb_read(vga_pkg::addr_ctrl, rd, err);
        check_value("ctrl", rd, 0);
        check_value("pslverr", err, 0);
        apb_read(vga_pkg::addr_color, rd, err);
        check_value("color", rd, 0);
        apb_read(vga_pkg::addr_status, rd, err);
        check_value("status", rd, 0);
        apb_read(4'hc, rd, err);
        check_value("pslverr on 0xc read", err, 1);
        apb_write(vga_pkg::addr_status, 32'h0000_1234, err);
        check_value("pslverr on status write", err, 1);
        finish_test("reset and defaults", e0);
    endtask

    task automatic test_sync_timing();
        int     e0;
        longint t0;
        longint t1;
        longint t2;
        e0 = errors;
        @(negedge hsync);
        t0 = $time;
        @(posedge hsync);
        t1 = $time;
        @(negedge hsync);
        t2 = $time;
        check_value("hsync low cycles", int'((t1 - t0) / clk_period), 96);
        check_value("hsync period cycles", int'((t2 - t0) / clk_period), 800);
        @(negedge vsync);
        t0 = $time;
        @(posedge vsync);
        t1 = $time;
        @(negedge vsync);
        t2 = $time;
        check_value("vsync low cycles", int'((t1 - t0) / clk_period), 2 * 800);
        check_value("vsync period cycles", int'((t2 - t0) / clk_period), frame_cycles);
        finish_test("sync timing", e0);
    endtask

    task automatic test_solid_staging();
        int          e0;
        logic [31:0] rd;
        logic        err;
        e0 = errors;
        fg_a = 3'(1 + $urandom % 7); // never black
        bg_a = 3'($urandom % 8);
        apb_write(vga_pkg::addr_color, {26'd0, bg_a, fg_a}, err);
        check_value("pslverr", err, 0);
        apb_write(vga_pkg::addr_ctrl, {29'd0, vga_pkg::mode_solid, 1'b1}, err);
        apb_read(vga_pkg::addr_color, rd, err);
        check_value("color", rd, {26'd0, bg_a, fg_a});
        apb_read(vga_pkg::addr_ctrl, rd, err);
        check_value("ctrl", rd, 1);
        wait_frame_end(1'b0, vga_pkg::mode_solid, 3'd0, 3'd0);
        make_spread_points();
        check_points(vga_pkg::mode_solid, fg_a, bg_a);
        finish_test("solid color and staging", e0);
    endtask

    task automatic test_bars_checker();
        int   e0;
        logic err;
        e0 = errors;
        apb_write(vga_pkg::addr_ctrl, {29'd0, vga_pkg::mode_bars, 1'b1}, err);
        wait_frame_end(1'b1, vga_pkg::mode_solid, fg_a, bg_a); // old frame stays solid
        make_spread_points();
        check_points(vga_pkg::mode_bars, fg_a, bg_a);
        fg_b = 3'(1 + $urandom % 7);
        bg_b = fg_b ^ 3'(1 + $urandom % 7);
        apb_write(vga_pkg::addr_color, {26'd0, bg_b, fg_b}, err);
        apb_write(vga_pkg::addr_ctrl, {29'd0, vga_pkg::mode_checker, 1'b1}, err);
        wait_frame_end(1'b1, vga_pkg::mode_bars, fg_a, bg_a);
        make_spread_points();
        check_points(vga_pkg::mode_checker, fg_b, bg_b);
        finish_test("color bars and checkerboard", e0);
    endtask

    task automatic test_border_counter();
        int          e0;
        logic [31:0] rd;
        logic        err;
        e0 = errors;
        apb_write(vga_pkg::addr_ctrl, {29'd0, vga_pkg::mode_border, 1'b1}, err);
        wait_frame_end(1'b1, vga_pkg::mode_checker, fg_b, bg_b);
        make_border_points();
        check_points(vga_pkg::mode_border, fg_b, bg_b);
        apb_read(vga_pkg::addr_status, rd, err);
        check_value("status frame count", rd, fe_count);
        check_value("pslverr", err, 0);
        finish_test("border and frame counter", e0);
    endtask

    initial begin
        void'($urandom(32'h9f0d_8e58));
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        fe_count     = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_defaults();
        test_sync_timing();
        test_solid_staging();
        test_bars_checker();
        test_border_counter();
        errors = errors + u_dut.u_asserts.fail_cnt; // concurrent assertion failures
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
src/vga_pkg.sv
src/vga_timing.sv
src/vga_regs.sv
src/pixel_pattern.sv
src/vga_top.sv
verif/vga_asserts.sv
verif/tb_vga.sv

//--- run.sh
#!/bin/sh
# build tb_vga with Verilator, run it, and decide pass or fail from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_vga -f filelist.f -o sim_vga \
    && ./obj_dir/sim_vga +verilator+error+limit+100 > sim.log 2>&1 \
    || { echo "build or simulation run failed, see sim.log"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation reported failures, see sim.log"; exit 1; }
